// File: run.sh
#!/bin/sh
# build with Verilator, run, then search the log for the fail verdict
# an aborted run (assertion stop, crash) is logged as a failure

verilator --binary --timing --assert -f src.f --top-module dx_tb -o dx_sim \
  && { ./obj_dir/dx_sim > sim.log 2>&1 || echo ">>> FAIL" >> sim.log; } \
  && cat sim.log \
  && ! grep -q ">>> FAIL" sim.log \
  || { echo "simulation failed"; exit 1; }

echo "simulation passed"

// File: src.f
verilog/dx_pkg.sv
verilog/dx_queue.sv
verilog/dx_execute.sv
verilog/dx_top.sv
tests/dx_checker.sv
tests/dx_scoreboard.sv
tests/dx_tb.sv

// File: tests/dx_checker.sv
//--------------------------------------------------------------------------
// concurrent assertions on the dx_top ports, attached by bind
// output hold under back-pressure, reset state of squash, known in_rdy
//--------------------------------------------------------------------------

module dx_checker (
  input logic               clk,
  input logic               rst_n,
  input logic               in_rdy,
  input logic               out_val,
  input logic               out_rdy,
  input dx_pkg::dx_wb_msg   out_msg,
  input dx_pkg::dx_redirect redirect
);

  timeunit 1ns;
  timeprecision 1ps;

  // stalled output keeps valid and payload
  out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_val && !out_rdy |=> out_val && $stable(out_msg))
    else $error("out_val or out_msg changed while out_rdy was low");

  // nothing accepted yet, so no squash
  squash_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !redirect.squash)
    else $error("squash high in the first cycle after reset");

  // ready must be known once out of reset
  in_rdy_known: assert property (@(posedge clk) rst_n |-> !$isunknown(in_rdy))
    else $error("in_rdy is unknown after reset");

endmodule

bind dx_top dx_checker chk (
  .clk      (clk),
  .rst_n    (rst_n),
  .in_rdy   (in_rdy),
  .out_val  (out_val),
  .out_rdy  (out_rdy),
  .out_msg  (out_msg),
  .redirect (redirect)
);

// File: tests/dx_scoreboard.sv
//--------------------------------------------------------------------------
// reference model for the dx_top ports
// replays accepted micro-ops in order, compares writebacks and squashes
//--------------------------------------------------------------------------

module dx_scoreboard (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_val,
  input  logic               in_rdy,
  input  dx_pkg::dx_msg      in_msg,
  input  logic               out_val,
  input  logic               out_rdy,
  input  dx_pkg::dx_wb_msg   out_msg,
  input  dx_pkg::dx_redirect redirect,
  output int                 errors,
  output int                 wb_checked,
  output int                 tgt_checked,
  output int                 pending
);

  timeunit 1ns;
  timeprecision 1ps;

  import dx_pkg::*;

  // expected results in arrival order
  dx_wb_msg    exp_wb [$];
  logic [31:0] exp_tgt [$];
  dx_wb_msg    head;

  // model copy of the wrong-path state
  logic        model_wrong_path = 1'b0;
  logic [31:0] model_target = '0;

  int err_count = 0;
  int wb_count  = 0;
  int tgt_count = 0;
  int open_cnt  = 0;

  assign errors      = err_count;
  assign wb_checked  = wb_count;
  assign tgt_checked = tgt_count;
  assign pending     = open_cnt;

  task automatic check_field(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    if (exp !== got) begin
      $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
      err_count++;
    end
  endtask

  //--------------------------------------------------------------------------
  // execute rules applied to one accepted micro-op at a time
  //--------------------------------------------------------------------------

  task automatic model_uop(input dx_msg m);
    logic [31:0] result;
    logic        taken;
    logic        branch;
    dx_wb_msg    wb;
    // wrong-path micro-op dropped without effect
    if (model_wrong_path && m.pc != model_target) return;
    result = '0;
    taken  = 1'b0;
    branch = 1'b0;
    case (m.uop)
      uop_add: result = m.op1 + m.op2;
      uop_sub: result = m.op1 - m.op2;
      uop_and: result = m.op1 & m.op2;
      uop_or:  result = m.op1 | m.op2;
      uop_xor: result = m.op1 ^ m.op2;
      uop_slt: result = ($signed(m.op1) < $signed(m.op2)) ? 32'd1 : 32'd0;
      uop_sll: result = m.op1 << m.op2[4:0];
      uop_srl: result = m.op1 >> m.op2[4:0];
      uop_beq: begin
        branch = 1'b1;
        taken  = (m.op1 == m.op2);
      end
      uop_bne: begin
        branch = 1'b1;
        taken  = (m.op1 != m.op2);
      end
      uop_blt: begin
        branch = 1'b1;
        taken  = ($signed(m.op1) < $signed(m.op2));
      end
      uop_jal: begin
        result = m.pc + 32'd4;
        taken  = 1'b1;
      end
      default: result = '0;
    endcase
    if (m.waddr != 5'd0 && !branch) begin
      wb.pc    = m.pc;
      wb.waddr = m.waddr;
      wb.data  = result;
      exp_wb.push_back(wb);
    end
    if (taken) begin
      exp_tgt.push_back(m.pc + m.imm);
      model_target = m.pc + m.imm;
    end
    model_wrong_path = taken;
  endtask

  //--------------------------------------------------------------------------
  // sampling at the falling edge where the ports are stable
  //--------------------------------------------------------------------------

  always @(negedge clk) begin
    if (!rst_n) begin
      exp_wb.delete();
      exp_tgt.delete();
      model_wrong_path = 1'b0;
    end else begin
      if (out_val && out_rdy) begin
        if (exp_wb.size() == 0) begin
          $display("unexpected writeback for pc %h at t=%0t", out_msg.pc, $time);
          err_count++;
        end else begin
          head = exp_wb.pop_front();
          check_field("out_msg.pc", head.pc, out_msg.pc);
          check_field("out_msg.waddr", 32'(head.waddr), 32'(out_msg.waddr));
          check_field("out_msg.data", head.data, out_msg.data);
          wb_count++;
        end
      end
      if (redirect.squash) begin
        if (exp_tgt.size() == 0) begin
          $display("squash to %h at t=%0t with no taken branch pending",
                   redirect.branch_target, $time);
          err_count++;
        end else begin
          check_field("redirect.branch_target", exp_tgt.pop_front(),
                      redirect.branch_target);
          tgt_count++;
        end
      end
      if (in_val && in_rdy) begin
        model_uop(in_msg);
      end
    end
    open_cnt = exp_wb.size() + exp_tgt.size();
  end

endmodule

// File: tests/dx_tb.sv
//--------------------------------------------------------------------------
// testbench for dx_top: seeded random micro-op streams in six phases
// scoreboard compares writebacks and squashes, verdict at the end
//--------------------------------------------------------------------------

module dx_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import dx_pkg::*;

  localparam int rdy_timeout   = 1000;
  localparam int drain_timeout = 2000;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        in_val;
  logic        in_rdy;
  dx_msg       in_msg;
  logic        out_val;
  logic        out_rdy;
  dx_wb_msg    out_msg;
  dx_redirect  redirect;

  int          errors;
  int          wb_checked;
  int          tgt_checked;
  int          pending;

  // run state
  logic        bp_mode;
  logic        timed_out;
  logic [31:0] pc_next;
  logic [31:0] br_pc;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm;
  dx_uop       br;
  int          k;
  int          tests_run;
  int          tests_failed;
  int          err_mark;

  always #4 clk = ~clk;

  // consumer, random stalls only in the back-pressure phase
  always @(posedge clk) begin
    #1;
    out_rdy = bp_mode ? ($urandom % 2 == 0) : 1'b1;
  end

  dx_top dut (.*);

  dx_scoreboard sb (.*);

  function automatic dx_msg make_msg(input logic [31:0] pc, input dx_uop uop,
                                     input logic [31:0] op1, input logic [31:0] op2,
                                     input logic [31:0] im, input logic [4:0] waddr);
    dx_msg m;
    m.pc    = pc;
    m.op1   = op1;
    m.op2   = op2;
    m.imm   = im;
    m.waddr = waddr;
    m.uop   = uop;
    return m;
  endfunction

  function automatic dx_uop pick_alu();
    return dx_uop'(4'($urandom % 8));
  endfunction

  // called 1 ns after a rising edge, returns the same way
  task automatic send_uop(input dx_msg m);
    int waited;
    waited = 0;
    if (timed_out) return;
    in_val = 1'b1;
    in_msg = m;
    @(negedge clk);
    while (!in_rdy && waited < rdy_timeout) begin
      @(negedge clk);
      waited++;
    end
    if (!in_rdy) begin
      $display("in_rdy stayed low for %0d cycles, pc %h never accepted", waited, m.pc);
      timed_out = 1'b1;
    end
    @(posedge clk);
    #1;
    in_val = 1'b0;
  endtask

  // random alu op at the next sequential pc
  task automatic issue_alu(input logic [4:0] waddr);
    send_uop(make_msg(pc_next, pick_alu(), $urandom, $urandom, $urandom, waddr));
    pc_next = pc_next + 32'd4;
  endtask

  // nothing expected and output idle for 8 cycles in a row
  task automatic wait_drain(input string name);
    int quiet;
    int cycles;
    quiet  = 0;
    cycles = 0;
    if (timed_out) return;
    while (quiet < 8 && cycles < drain_timeout) begin
      @(negedge clk);
      cycles++;
      quiet = (pending == 0 && !out_val) ? quiet + 1 : 0;
    end
    if (quiet < 8) begin
      $display("%s did not drain, %0d results still expected", name, pending);
      timed_out = 1'b1;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic close_phase(input string name);
    int new_err;
    wait_drain(name);
    new_err = errors - err_mark;
    err_mark = errors;
    tests_run++;
    if (new_err != 0 || timed_out) tests_failed++;
    $display("test %0d %s: %s, %0d errors", tests_run, name,
             (new_err == 0 && !timed_out) ? "ok" : "failed", new_err);
  endtask

  initial begin
    void'($urandom(32'hdc92_e0f6));
    rst_n = 1'b0;
    in_val = 1'b0;
    in_msg = '0;
    out_rdy = 1'b1;
    bp_mode = 1'b0;
    timed_out = 1'b0;
    pc_next = 32'h0000_1000;
    tests_run = 0;
    tests_failed = 0;
    err_mark = 0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    repeat (40) issue_alu(5'($urandom_range(1, 31)));
    close_phase("alu ops");

    // about half the ops target x0
    repeat (40) issue_alu(($urandom % 2 == 0) ? 5'd0 : 5'($urandom_range(1, 31)));
    close_phase("writes to x0");

    // beq, bne, blt, jal in turn, each forced taken, target sent next
    for (k = 0; k < 8; k++) begin
      br = dx_uop'(4'(8 + k % 4));
      a = $urandom;
      b = $urandom;
      if (br == uop_beq) b = a;
      if (br == uop_bne) b = a ^ 32'h10;
      if (br == uop_blt) begin
        a[31] = 1'b1;
        b[31] = 1'b0;
      end
      imm = 32'($urandom_range(2, 16)) << 2;
      send_uop(make_msg(pc_next, br, a, b, imm, 5'($urandom_range(1, 31))));
      pc_next = pc_next + imm;
      issue_alu(5'($urandom_range(1, 31)));
    end
    close_phase("taken branches");

    // taken beq, three alu ops and a jal on the wrong path, then target
    for (k = 0; k < 4; k++) begin
      br_pc = pc_next;
      a = $urandom;
      send_uop(make_msg(br_pc, uop_beq, a, a, 32'd24, 5'd0));
      pc_next = br_pc + 32'd4;
      repeat (3) issue_alu(5'($urandom_range(1, 31)));
      send_uop(make_msg(pc_next, uop_jal, 32'd0, 32'd0, 32'd64, 5'd7));
      pc_next = br_pc + 32'd24;
      issue_alu(5'($urandom_range(1, 31)));
    end
    close_phase("wrong-path filter");

    // operands chosen so that no branch is taken
    for (k = 0; k < 12; k++) begin
      br = dx_uop'(4'(8 + k % 3));
      a = $urandom;
      b = a;
      if (br == uop_beq) b = a ^ 32'h1;
      if (br == uop_blt) begin
        a[31] = 1'b0;
        b[31] = 1'b1;
      end
      send_uop(make_msg(pc_next, br, a, b, 32'd32, 5'($urandom_range(1, 31))));
      pc_next = pc_next + 32'd4;
      issue_alu(5'($urandom_range(1, 31)));
    end
    close_phase("not-taken branches");

    @(negedge clk);
    bp_mode = 1'b1;
    @(posedge clk);
    #1;
    // random mix, branch target at pc+8 so either outcome stays in sync
    repeat (60) begin
      if ($urandom % 4 == 0) begin
        br = dx_uop'(4'(8 + $urandom % 4));
        a = $urandom;
        b = ($urandom % 2 == 0) ? a : $urandom;
        br_pc = pc_next;
        send_uop(make_msg(br_pc, br, a, b, 32'd8, 5'($urandom % 32)));
        pc_next = br_pc + 32'd4;
        issue_alu(5'($urandom_range(1, 31)));
        pc_next = br_pc + 32'd8;
      end else begin
        issue_alu(5'($urandom % 32));
      end
    end
    close_phase("back-pressure");
    bp_mode = 1'b0;

    $display("tests %0d, failed %0d, writebacks checked %0d, redirects checked %0d, errors %0d",
             tests_run, tests_failed, wb_checked, tgt_checked, errors);
    if (errors == 0 && tests_failed == 0 && !timed_out) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: verilog/dx_execute.sv
//--------------------------------------------------------------------------
// execute stage: alu, branch and jump resolution
// registers one writeback and one redirect pulse per accepted micro-op,
// drops wrong-path micro-ops until the pending branch target shows up
//--------------------------------------------------------------------------

module dx_execute (
  input  logic                 clk,
  input  logic                 rst_n,

  // head of the input queue
  input  logic                 x_val,
  output logic                 x_rdy,
  input  dx_pkg::dx_msg        x_msg,

  // writeback towards the output queue
  output logic                 wb_val,
  input  logic                 wb_rdy,
  output dx_pkg::dx_wb_msg     wb_msg,

  // squash pulse, no handshake
  output dx_pkg::dx_redirect   redirect
);

  import dx_pkg::*;

  // combinational decode of the head
  logic        is_branch;
  logic        taken;
  logic [31:0] alu_result;
  logic [31:0] target;
  logic        discard;
  logic        writes;
  logic        slot_free;
  logic        accept;

  // wrong-path tracking
  logic        wrong_path_q;
  logic [31:0] pend_target_q;

  // registered outputs
  logic        wb_val_q;
  dx_wb_msg    wb_msg_q;
  logic        squash_q;
  logic [31:0] br_target_q;

  //--------------------------------------------------------------------------
  // alu and branch decision
  //--------------------------------------------------------------------------

  always_comb begin
    alu_result = '0;
    taken      = 1'b0;
    is_branch  = 1'b0;
    case (x_msg.uop)
      uop_add: alu_result = x_msg.op1 + x_msg.op2;
      uop_sub: alu_result = x_msg.op1 - x_msg.op2;
      uop_and: alu_result = x_msg.op1 & x_msg.op2;
      uop_or:  alu_result = x_msg.op1 | x_msg.op2;
      uop_xor: alu_result = x_msg.op1 ^ x_msg.op2;
      // signed compare, zero extended flag
      uop_slt: alu_result = {31'b0, $signed(x_msg.op1) < $signed(x_msg.op2)};
      uop_sll: alu_result = x_msg.op1 << x_msg.op2[4:0];
      uop_srl: alu_result = x_msg.op1 >> x_msg.op2[4:0];
      uop_beq: begin
        is_branch = 1'b1;
        taken     = (x_msg.op1 == x_msg.op2);
      end
      uop_bne: begin
        is_branch = 1'b1;
        taken     = (x_msg.op1 != x_msg.op2);
      end
      uop_blt: begin
        is_branch = 1'b1;
        taken     = ($signed(x_msg.op1) < $signed(x_msg.op2));
      end
      // link address written, always redirects
      uop_jal: begin
        alu_result = x_msg.pc + 32'd4;
        taken      = 1'b1;
      end
      default: alu_result = '0;
    endcase
  end

  // same target form for branches and jal
  assign target = x_msg.pc + x_msg.imm;

  // wrong path until the stored target pc arrives
  assign discard = wrong_path_q && (x_msg.pc != pend_target_q);

  // x0 and branches never write
  assign writes = !discard && (x_msg.waddr != 5'd0) && !is_branch;

  //--------------------------------------------------------------------------
  // handshake
  //--------------------------------------------------------------------------

  // slot empties this cycle or already empty
  assign slot_free = !wb_val_q || wb_rdy;
  assign x_rdy     = slot_free || !writes;
  assign accept    = x_val && x_rdy;

  //--------------------------------------------------------------------------
  // control state
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_val_q     <= 1'b0;
      squash_q     <= 1'b0;
      wrong_path_q <= 1'b0;
    end else begin
      if (accept && writes) begin
        wb_val_q <= 1'b1;
      end else if (wb_rdy) begin
        wb_val_q <= 1'b0;
      end
      // one-cycle pulse per taken op on the right path
      squash_q <= accept && !discard && taken;
      // a matching target clears the flag, unless it redirects again
      if (accept && !discard) begin
        wrong_path_q <= taken;
      end
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (accept && writes) begin
      wb_msg_q.pc    <= x_msg.pc;
      wb_msg_q.waddr <= x_msg.waddr;
      wb_msg_q.data  <= alu_result;
    end
    if (accept && !discard && taken) begin
      pend_target_q <= target;
      br_target_q   <= target;
    end
  end

  assign wb_val   = wb_val_q;
  assign wb_msg   = wb_msg_q;
  assign redirect = '{squash: squash_q, branch_target: br_target_q};

endmodule

// File: verilog/dx_pkg.sv
//--------------------------------------------------------------------------
// shared types and constants for the decode-to-execute boundary
// micro-op opcodes, message structs and queue depths used by the RTL
// and by the testbench model
//--------------------------------------------------------------------------

package dx_pkg;

  //--------------------------------------------------------------------------
  // opcodes
  //--------------------------------------------------------------------------

  // 4-bit micro-op encoding, alu ops first, then control flow
  typedef enum logic [3:0] {
    uop_add = 4'd0,
    uop_sub = 4'd1,
    uop_and = 4'd2,
    uop_or  = 4'd3,
    uop_xor = 4'd4,
    uop_slt = 4'd5,
    uop_sll = 4'd6,
    uop_srl = 4'd7,
    uop_beq = 4'd8,
    uop_bne = 4'd9,
    uop_blt = 4'd10,
    uop_jal = 4'd11
  } dx_uop;

  //--------------------------------------------------------------------------
  // messages
  //--------------------------------------------------------------------------

  // decoded micro-op, 137 bits
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] imm;
    logic [4:0]  waddr;
    dx_uop       uop;
  } dx_msg;

  // writeback to the register file side, 69 bits
  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  waddr;
    logic [31:0] data;
  } dx_wb_msg;

  // squash pulse plus new fetch address, 33 bits
  typedef struct packed {
    logic        squash;
    logic [31:0] branch_target;
  } dx_redirect;

  // queue depths, both fit the shared pointer width
  localparam int DX_IN_DEPTH  = 4;
  localparam int DX_OUT_DEPTH = 4;
  localparam int DX_PTR_W     = 2;

endpackage

// File: verilog/dx_queue.sv
//--------------------------------------------------------------------------
// valid/ready FIFO with a type parameter for the payload
// serves decoded micro-ops on the input side and writebacks on the output
//--------------------------------------------------------------------------

module dx_queue #(
  parameter type t_msg   = dx_pkg::dx_msg,
  parameter int  p_depth = dx_pkg::DX_IN_DEPTH
) (
  input  logic clk,
  input  logic rst_n,

  // producer side
  input  logic push_val,
  output logic push_rdy,
  input  t_msg push_msg,

  // consumer side
  output logic pop_val,
  input  logic pop_rdy,
  output t_msg pop_msg
);

  import dx_pkg::*;

  // wrap mask, depth is a power of two
  localparam logic [DX_PTR_W-1:0] ptr_mask = DX_PTR_W'(p_depth - 1);
  localparam logic [DX_PTR_W:0]   full_cnt = (DX_PTR_W + 1)'(p_depth);

  // storage
  t_msg mem [p_depth];

  logic [DX_PTR_W-1:0] wr_ptr_q;
  logic [DX_PTR_W-1:0] rd_ptr_q;
  logic [DX_PTR_W:0]   count_q;

  logic do_push;
  logic do_pop;

  //--------------------------------------------------------------------------
  // handshake
  //--------------------------------------------------------------------------

  // full blocks the producer, empty blocks the consumer
  assign push_rdy = (count_q != full_cnt);
  assign pop_val  = (count_q != '0);
  assign pop_msg  = mem[rd_ptr_q];

  assign do_push = push_val && push_rdy;
  assign do_pop  = pop_val && pop_rdy;

  //--------------------------------------------------------------------------
  // pointers and count
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q + 1'b1) & ptr_mask;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q + 1'b1) & ptr_mask;
      end
      // simultaneous push and pop leaves count alone
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // payload write, head readable the following cycle
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= push_msg;
    end
  end

endmodule

// File: verilog/dx_top.sv
//--------------------------------------------------------------------------
// decode-to-execute boundary: input queue, execute, output queue
// micro-ops in on a valid/ready port, writebacks out under back-pressure
//--------------------------------------------------------------------------

module dx_top (
  input  logic               clk,
  input  logic               rst_n,

  // decoded micro-ops from the producer
  input  logic               in_val,
  output logic               in_rdy,
  input  dx_pkg::dx_msg      in_msg,

  // writebacks to the consumer
  output logic               out_val,
  input  logic               out_rdy,
  output dx_pkg::dx_wb_msg   out_msg,

  // taken branch or jump
  output dx_pkg::dx_redirect redirect
);

  import dx_pkg::*;

  //--------------------------------------------------------------------------
  // internal ports
  //--------------------------------------------------------------------------

  // input queue head into execute
  logic     x_val;
  logic     x_rdy;
  dx_msg    x_msg;

  // execute into output queue
  logic     wb_val;
  logic     wb_rdy;
  dx_wb_msg wb_msg;

  // input side
  dx_queue #(
    .t_msg   (dx_msg),
    .p_depth (DX_IN_DEPTH)
  ) in_q (
    .clk      (clk),
    .rst_n    (rst_n),
    .push_val (in_val),
    .push_rdy (in_rdy),
    .push_msg (in_msg),
    .pop_val  (x_val),
    .pop_rdy  (x_rdy),
    .pop_msg  (x_msg)
  );

  // processing
  dx_execute exec (
    .clk      (clk),
    .rst_n    (rst_n),
    .x_val    (x_val),
    .x_rdy    (x_rdy),
    .x_msg    (x_msg),
    .wb_val   (wb_val),
    .wb_rdy   (wb_rdy),
    .wb_msg   (wb_msg),
    .redirect (redirect)
  );

  // output side
  dx_queue #(
    .t_msg   (dx_wb_msg),
    .p_depth (DX_OUT_DEPTH)
  ) out_q (
    .clk      (clk),
    .rst_n    (rst_n),
    .push_val (wb_val),
    .push_rdy (wb_rdy),
    .push_msg (wb_msg),
    .pop_val  (out_val),
    .pop_rdy  (out_rdy),
    .pop_msg  (out_msg)
  );

endmodule
